// File: verilog/cq_cfg_pkg.sv
`default_nettype none

package cq_cfg_pkg;

  // ------------------------------------------------------------------
  // queue geometry
  // ------------------------------------------------------------------

  // number of queues under accounting
  localparam int unsigned NUM_QUEUES = 4;
  // occupancy and limit width, so 255 entries at most
  localparam int unsigned OCC_W = 8;
  // drop counter width
  localparam int unsigned DROP_W = 12;
  // queue index width, log2 of NUM_QUEUES
  localparam int unsigned QID_W = 2;

  // limit every queue comes out of reset with
  localparam int unsigned DEFAULT_LIMIT = 16;

  // ------------------------------------------------------------------
  // configuration write targets
  // ------------------------------------------------------------------
  localparam logic [1:0] CFG_LIMIT = 2'd0;
  localparam logic [1:0] CFG_OCC = 2'd1;
  localparam logic [1:0] CFG_DROP = 2'd2;

endpackage

`default_nettype wire

// File: verilog/cq_types_pkg.sv
`default_nettype none

package cq_types_pkg;

  import cq_cfg_pkg::*;

  // one occupancy count, also used for limits and dequeue amounts
  typedef logic [OCC_W-1:0] occ_t;

  // one drop count
  typedef logic [DROP_W-1:0] drop_t;

  // queue index
  typedef logic [QID_W-1:0] qid_t;

  // one bit per queue, e.g. the flush mask
  typedef logic [NUM_QUEUES-1:0] qmask_t;

  // which field a configuration write targets
  typedef logic [1:0] cfg_sel_t;

endpackage

`default_nettype wire

// File: verilog/counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module counter_bank #(
  parameter int NUM = 1
  , parameter int DWIDTH = 16
) (
  input  logic                    clk
  , input  logic                  rst_n
  , input  logic [NUM-1:0]        inc
  , input  logic [NUM*DWIDTH-1:0] inc_amount
  , input  logic [NUM-1:0]        dec
  , input  logic [NUM*DWIDTH-1:0] dec_amount
  , input  logic [NUM-1:0]        clr
  , input  logic [NUM-1:0]        load
  , input  logic [NUM*DWIDTH-1:0] load_value
  , output logic [NUM*DWIDTH-1:0] counter
);

  // registered lanes and their next values
  logic [NUM*DWIDTH-1:0] count_q;
  logic [NUM*DWIDTH-1:0] count_d;

  // ------------------------------------------------------------------
  // next value per lane
  // ------------------------------------------------------------------
  // operations apply in order, so the last one that is set wins
  always_comb begin
    logic [DWIDTH-1:0] lane;
    count_d = count_q;
    for (int i = 0; i < NUM; i++) begin
      lane = count_q[i*DWIDTH +: DWIDTH];
      if (inc[i]) begin
        lane = lane + inc_amount[i*DWIDTH +: DWIDTH];
      end
      if (dec[i]) begin
        lane = lane - dec_amount[i*DWIDTH +: DWIDTH];
      end
      // clear beats inc and dec
      if (clr[i]) begin
        lane = '0;
      end
      // load beats everything
      if (load[i]) begin
        lane = load_value[i*DWIDTH +: DWIDTH];
      end
      count_d[i*DWIDTH +: DWIDTH] = lane;
    end
  end

  // all lanes start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign counter = count_q;

endmodule

`default_nettype wire

// File: verilog/credit_admit.sv
`timescale 1ns/1ps
`default_nettype none

module credit_admit
  import cq_cfg_pkg::*;
  import cq_types_pkg::*;
(
  input  logic                     clk
  , input  logic                   rst_n
  // request strobes
  , input  logic                   enq_valid
  , input  qid_t                   enq_qid
  , input  logic                   deq_valid
  , input  qid_t                   deq_qid
  , input  occ_t                   deq_amount
  , input  qmask_t                 flush
  , input  logic                   cfg_wr
  , input  cfg_sel_t               cfg_sel
  , input  qid_t                   cfg_qid
  , input  occ_t                   cfg_value
  // registered counts fed back from the banks
  , input  occ_t [NUM_QUEUES-1:0]  occupancy
  , input  drop_t [NUM_QUEUES-1:0] drops
  // answers
  , output logic                   enq_accept
  , output logic                   deq_underflow
  // occupancy bank strobes
  , output qmask_t                 occ_inc
  , output occ_t [NUM_QUEUES-1:0]  occ_inc_amount
  , output qmask_t                 occ_dec
  , output occ_t [NUM_QUEUES-1:0]  occ_dec_amount
  , output qmask_t                 occ_clr
  , output qmask_t                 occ_load
  , output occ_t [NUM_QUEUES-1:0]  occ_load_value
  // drop bank strobes
  , output qmask_t                 drop_inc
  , output drop_t [NUM_QUEUES-1:0] drop_inc_amount
  , output qmask_t                 drop_dec
  , output drop_t [NUM_QUEUES-1:0] drop_dec_amount
  , output qmask_t                 drop_clr
  , output qmask_t                 drop_load
  , output drop_t [NUM_QUEUES-1:0] drop_load_value
);

  // per-queue admission limits
  occ_t [NUM_QUEUES-1:0] limit;

  // selected-queue views
  occ_t enq_occ;
  occ_t enq_limit;
  occ_t deq_occ;
  // dequeue amount after clamping to the occupancy
  occ_t deq_take;

  logic enq_refuse;
  logic cfg_occ_wr;
  logic cfg_drop_wr;

  // ------------------------------------------------------------------
  // limit registers
  // ------------------------------------------------------------------
  // a new limit is seen by admission from the next cycle on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
        limit[q] <= occ_t'(DEFAULT_LIMIT);
      end
    end else if (cfg_wr && (cfg_sel == CFG_LIMIT)) begin
      limit[cfg_qid] <= cfg_value;
    end
  end

  // ------------------------------------------------------------------
  // admission and dequeue clamp
  // ------------------------------------------------------------------
  assign enq_occ = occupancy[enq_qid];
  assign enq_limit = limit[enq_qid];
  assign deq_occ = occupancy[deq_qid];

  // judged on the occupancy before any same-cycle dequeue
  assign enq_accept = enq_valid && (enq_occ < enq_limit);
  assign enq_refuse = enq_valid && !enq_accept;

  // asking for more than is held returns only what is held
  assign deq_underflow = deq_valid && (deq_amount > deq_occ);
  assign deq_take = deq_underflow ? deq_occ : deq_amount;

  // direct counter writes
  assign cfg_occ_wr = cfg_wr && (cfg_sel == CFG_OCC);
  assign cfg_drop_wr = cfg_wr && (cfg_sel == CFG_DROP);

  // ------------------------------------------------------------------
  // per-lane strobes for both banks
  // ------------------------------------------------------------------
  // bank priority does the rest: flush beats enq/deq, load beats flush
  always_comb begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      occ_inc[q] = enq_accept && (enq_qid == qid_t'(q));
      occ_inc_amount[q] = occ_t'(1);
      occ_dec[q] = deq_valid && (deq_qid == qid_t'(q));
      occ_dec_amount[q] = deq_take;
      occ_clr[q] = flush[q];
      occ_load[q] = cfg_occ_wr && (cfg_qid == qid_t'(q));
      occ_load_value[q] = cfg_value;

      drop_inc[q] = enq_refuse && (enq_qid == qid_t'(q));
      drop_inc_amount[q] = drop_t'(1);
      // drop count sticks at full scale, the +1 and -1 cancel
      drop_dec[q] = drop_inc[q] && (drops[q] == '1);
      drop_dec_amount[q] = drop_t'(1);
      drop_clr[q] = flush[q];
      drop_load[q] = cfg_drop_wr && (cfg_qid == qid_t'(q));
      // cfg_value is narrower, zero extended
      drop_load_value[q] = drop_t'(cfg_value);
    end
  end

endmodule

`default_nettype wire

// File: verilog/occupancy_peak.sv
`timescale 1ns/1ps
`default_nettype none

module occupancy_peak
  import cq_cfg_pkg::*;
  import cq_types_pkg::*;
(
  input  logic                    clk
  , input  logic                  rst_n
  // registered occupancy of every queue
  , input  occ_t [NUM_QUEUES-1:0] occupancy
  , input  qmask_t                flush
  , output occ_t [NUM_QUEUES-1:0] peak
);

  // high-water marks
  occ_t [NUM_QUEUES-1:0] peak_q;
  occ_t [NUM_QUEUES-1:0] peak_d;

  // ------------------------------------------------------------------
  // next high-water mark
  // ------------------------------------------------------------------
  // lags the occupancy by one edge since it watches the bank output
  always_comb begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (flush[q]) begin
        // same edge that clears the occupancy
        peak_d[q] = '0;
      end else if (occupancy[q] > peak_q[q]) begin
        peak_d[q] = occupancy[q];
      end else begin
        peak_d[q] = peak_q[q];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_q <= '0;
    end else begin
      peak_q <= peak_d;
    end
  end

  assign peak = peak_q;

endmodule

`default_nettype wire

// File: verilog/credit_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module credit_monitor_top
  import cq_cfg_pkg::*;
  import cq_types_pkg::*;
(
  input  logic                     clk
  , input  logic                   rst_n
  , input  logic                   enq_valid
  , input  qid_t                   enq_qid
  , input  logic                   deq_valid
  , input  qid_t                   deq_qid
  , input  occ_t                   deq_amount
  , input  qmask_t                 flush
  , input  logic                   cfg_wr
  , input  cfg_sel_t               cfg_sel
  , input  qid_t                   cfg_qid
  , input  occ_t                   cfg_value
  , output logic                   enq_accept
  , output logic                   deq_underflow
  , output occ_t [NUM_QUEUES-1:0]  occupancy
  , output drop_t [NUM_QUEUES-1:0] drops
  , output occ_t [NUM_QUEUES-1:0]  peak
);

  // ------------------------------------------------------------------
  // bank strobes
  // ------------------------------------------------------------------
  qmask_t                 occ_inc;
  occ_t [NUM_QUEUES-1:0]  occ_inc_amount;
  qmask_t                 occ_dec;
  occ_t [NUM_QUEUES-1:0]  occ_dec_amount;
  qmask_t                 occ_clr;
  qmask_t                 occ_load;
  occ_t [NUM_QUEUES-1:0]  occ_load_value;

  qmask_t                 drop_inc;
  drop_t [NUM_QUEUES-1:0] drop_inc_amount;
  qmask_t                 drop_dec;
  drop_t [NUM_QUEUES-1:0] drop_dec_amount;
  qmask_t                 drop_clr;
  qmask_t                 drop_load;
  drop_t [NUM_QUEUES-1:0] drop_load_value;

  // admission, clamp and strobe decode
  credit_admit u_admit (
    .clk             (clk)
    , .rst_n           (rst_n)
    , .enq_valid       (enq_valid)
    , .enq_qid         (enq_qid)
    , .deq_valid       (deq_valid)
    , .deq_qid         (deq_qid)
    , .deq_amount      (deq_amount)
    , .flush           (flush)
    , .cfg_wr          (cfg_wr)
    , .cfg_sel         (cfg_sel)
    , .cfg_qid         (cfg_qid)
    , .cfg_value       (cfg_value)
    , .occupancy       (occupancy)
    , .drops           (drops)
    , .enq_accept      (enq_accept)
    , .deq_underflow   (deq_underflow)
    , .occ_inc         (occ_inc)
    , .occ_inc_amount  (occ_inc_amount)
    , .occ_dec         (occ_dec)
    , .occ_dec_amount  (occ_dec_amount)
    , .occ_clr         (occ_clr)
    , .occ_load        (occ_load)
    , .occ_load_value  (occ_load_value)
    , .drop_inc        (drop_inc)
    , .drop_inc_amount (drop_inc_amount)
    , .drop_dec        (drop_dec)
    , .drop_dec_amount (drop_dec_amount)
    , .drop_clr        (drop_clr)
    , .drop_load       (drop_load)
    , .drop_load_value (drop_load_value)
  );

  // occupancy counters, fed back to admission and peak
  counter_bank #(
    .NUM    (NUM_QUEUES)
    , .DWIDTH (OCC_W)
  ) occ_bank (
    .clk        (clk)
    , .rst_n      (rst_n)
    , .inc        (occ_inc)
    , .inc_amount (occ_inc_amount)
    , .dec        (occ_dec)
    , .dec_amount (occ_dec_amount)
    , .clr        (occ_clr)
    , .load       (occ_load)
    , .load_value (occ_load_value)
    , .counter    (occupancy)
  );

  // drop counters
  counter_bank #(
    .NUM    (NUM_QUEUES)
    , .DWIDTH (DROP_W)
  ) drop_bank (
    .clk        (clk)
    , .rst_n      (rst_n)
    , .inc        (drop_inc)
    , .inc_amount (drop_inc_amount)
    , .dec        (drop_dec)
    , .dec_amount (drop_dec_amount)
    , .clr        (drop_clr)
    , .load       (drop_load)
    , .load_value (drop_load_value)
    , .counter    (drops)
  );

  // high-water marks
  occupancy_peak u_peak (
    .clk       (clk)
    , .rst_n     (rst_n)
    , .occupancy (occupancy)
    , .flush     (flush)
    , .peak      (peak)
  );

endmodule

`default_nettype wire

// File: verif/credit_monitor_chk.sv
`timescale 1ns/1ps
`default_nettype none

module credit_monitor_chk
  import cq_cfg_pkg::*;
  import cq_types_pkg::*;
(
  input  logic                    clk
  , input  logic                  rst_n
  , input  logic                  enq_valid
  , input  logic                  enq_accept
  , input  logic                  deq_valid
  , input  logic                  deq_underflow
  , input  qmask_t                flush
  , input  logic                  cfg_wr
  , input  cfg_sel_t              cfg_sel
  , input  qid_t                  cfg_qid
  , input  occ_t [NUM_QUEUES-1:0] occupancy
  , input  occ_t [NUM_QUEUES-1:0] peak
);

  // number of failed assertions
  int fail_count = 0;

  // ------------------------------------------------------------------
  // answers only come with their request
  // ------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n) enq_accept |-> enq_valid)
    else begin
      $error("enq_accept high without enq_valid");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) deq_underflow |-> deq_valid)
    else begin
      $error("deq_underflow high without deq_valid");
      fail_count++;
    end

  // ------------------------------------------------------------------
  // per-lane bounds
  // ------------------------------------------------------------------
  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_lane
    // one edge adds at most one entry unless the count is written directly
    // so a dequeue that wrapped below zero shows up here
    assert property (@(posedge clk) disable iff (!rst_n)
      !(cfg_wr && (cfg_sel == CFG_OCC) && (cfg_qid == qid_t'(q)))
      |=> (occupancy[q] <= $past(occupancy[q]) + 1))
      else begin
        $error("occupancy lane %0d rose by more than one entry", q);
        fail_count++;
      end

    // peak trails occupancy by one edge, so compare against the last value
    assert property (@(posedge clk) disable iff (!rst_n)
      !flush[q] |=> (peak[q] >= $past(occupancy[q])))
      else begin
        $error("peak lane %0d below its occupancy", q);
        fail_count++;
      end
  end

endmodule

bind credit_monitor_top credit_monitor_chk u_chk (
  .clk             (clk)
  , .rst_n         (rst_n)
  , .enq_valid     (enq_valid)
  , .enq_accept    (enq_accept)
  , .deq_valid     (deq_valid)
  , .deq_underflow (deq_underflow)
  , .flush         (flush)
  , .cfg_wr        (cfg_wr)
  , .cfg_sel       (cfg_sel)
  , .cfg_qid       (cfg_qid)
  , .occupancy     (occupancy)
  , .peak          (peak)
);

`default_nettype wire

// File: verif/credit_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module credit_monitor_tb
  import cq_cfg_pkg::*;
  import cq_types_pkg::*;
();

  typedef logic [NUM_QUEUES*OCC_W-1:0] occ_vec_t;
  typedef logic [NUM_QUEUES*DROP_W-1:0] drop_vec_t;

  // one stimulus cycle plus what the DUT should answer
  typedef struct packed {
    logic      enq;
    qid_t      eqid;
    logic      deq;
    qid_t      dqid;
    occ_t      damt;
    qmask_t    fl;
    logic      cw;
    cfg_sel_t  csel;
    qid_t      cqid;
    occ_t      cval;
    logic      acc;
    logic      unf;
    occ_vec_t  occ;
    drop_vec_t drp;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic enq_valid;
  qid_t enq_qid;
  logic deq_valid;
  qid_t deq_qid;
  occ_t deq_amount;
  qmask_t flush;
  logic cfg_wr;
  cfg_sel_t cfg_sel;
  qid_t cfg_qid;
  occ_t cfg_value;
  logic enq_accept;
  logic deq_underflow;
  occ_t [NUM_QUEUES-1:0] occupancy;
  drop_t [NUM_QUEUES-1:0] drops;
  occ_t [NUM_QUEUES-1:0] peak;

  // reference model state
  occ_t [NUM_QUEUES-1:0] m_occ;
  drop_t [NUM_QUEUES-1:0] m_drop;
  occ_t [NUM_QUEUES-1:0] m_lim;
  occ_t [NUM_QUEUES-1:0] m_peak;

  row_t rows[$];
  int mismatch_count = 0;
  int other_count = 0;
  int wait_cycles;

  credit_monitor_top uut (
    .clk             (clk)
    , .rst_n         (rst_n)
    , .enq_valid     (enq_valid)
    , .enq_qid       (enq_qid)
    , .deq_valid     (deq_valid)
    , .deq_qid       (deq_qid)
    , .deq_amount    (deq_amount)
    , .flush         (flush)
    , .cfg_wr        (cfg_wr)
    , .cfg_sel       (cfg_sel)
    , .cfg_qid       (cfg_qid)
    , .cfg_value     (cfg_value)
    , .enq_accept    (enq_accept)
    , .deq_underflow (deq_underflow)
    , .occupancy     (occupancy)
    , .drops         (drops)
    , .peak          (peak)
  );

  // 4 ns period
  always #2 clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic add_row(input logic enq, input qid_t eqid, input logic deq, input qid_t dqid,
                         input occ_t damt, input qmask_t fl, input logic cw,
                         input cfg_sel_t csel, input qid_t cqid, input occ_t cval,
                         input logic acc, input logic unf, input occ_vec_t occ,
                         input drop_vec_t drp);
    rows.push_back({enq, eqid, deq, dqid, damt, fl, cw, csel, cqid, cval, acc, unf, occ, drp});
  endtask

  task automatic drive_inputs(input row_t r);
    enq_valid = r.enq;
    enq_qid = r.eqid;
    deq_valid = r.deq;
    deq_qid = r.dqid;
    deq_amount = r.damt;
    flush = r.fl;
    cfg_wr = r.cw;
    cfg_sel = r.csel;
    cfg_qid = r.cqid;
    cfg_value = r.cval;
  endtask

  // enq and deq both apply, then flush and then cfg override them in that order
  task automatic advance_model(input row_t r, output logic acc, output logic unf);
    occ_t take;
    begin
      acc = r.enq && (m_occ[r.eqid] < m_lim[r.eqid]);
      unf = r.deq && (r.damt > m_occ[r.dqid]);
      take = unf ? m_occ[r.dqid] : r.damt;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        // peak sees the occupancy from before this edge
        if (r.fl[q]) begin
          m_peak[q] = '0;
        end else if (m_occ[q] > m_peak[q]) begin
          m_peak[q] = m_occ[q];
        end
        if (acc && (r.eqid == qid_t'(q))) begin
          m_occ[q] = m_occ[q] + occ_t'(1);
        end
        if (r.deq && (r.dqid == qid_t'(q))) begin
          m_occ[q] = m_occ[q] - take;
        end
        if (r.enq && !acc && (r.eqid == qid_t'(q))) begin
          m_drop[q] = m_drop[q] + drop_t'(1);
        end
        if (r.fl[q]) begin
          m_occ[q] = '0;
          m_drop[q] = '0;
        end
        if (r.cw && (r.cqid == qid_t'(q)) && (r.csel == CFG_OCC)) begin
          m_occ[q] = r.cval;
        end
        if (r.cw && (r.cqid == qid_t'(q)) && (r.csel == CFG_DROP)) begin
          m_drop[q] = drop_t'(r.cval);
        end
      end
      if (r.cw && (r.csel == CFG_LIMIT)) begin
        m_lim[r.cqid] = r.cval;
      end
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic apply_row(input row_t r, input bit use_row);
    logic x_acc;
    logic x_unf;
    begin
      drive_inputs(r);
      #1;
      advance_model(r, x_acc, x_unf);
      compare_value("enq_accept", enq_accept, x_acc);
      compare_value("deq_underflow", deq_underflow, x_unf);
      if (use_row) begin
        compare_value("enq_accept (table)", enq_accept, r.acc);
        compare_value("deq_underflow (table)", deq_underflow, r.unf);
      end
      @(posedge clk);
      #1;
      compare_value("occupancy", occupancy, m_occ);
      compare_value("drops", drops, m_drop);
      compare_value("peak", peak, m_peak);
      if (use_row) begin
        compare_value("occupancy (table)", occupancy, r.occ);
        compare_value("drops (table)", drops, r.drp);
      end
    end
  endtask

  function automatic row_t random_row();
    row_t r;
    begin
      r = '0;
      r.enq = ($urandom % 4) != 0;
      r.eqid = qid_t'($urandom % NUM_QUEUES);
      r.deq = ($urandom % 3) == 0;
      r.dqid = qid_t'($urandom % NUM_QUEUES);
      r.damt = occ_t'($urandom % 8);
      r.fl = (($urandom % 16) == 0) ? qmask_t'($urandom) : '0;
      r.cw = ($urandom % 8) == 0;
      r.csel = cfg_sel_t'($urandom % 4);
      r.cqid = qid_t'($urandom % NUM_QUEUES);
      r.cval = occ_t'($urandom % 24);
      return r;
    end
  endfunction

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    drive_inputs('0);
    void'($urandom(32'h505a));
    m_occ = '0;
    m_drop = '0;
    m_peak = '0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      m_lim[q] = occ_t'(DEFAULT_LIMIT);
    end

    // enq eqid deq dqid damt flush cw csel cqid cval | acc unf occ drops
    for (int i = 0; i < DEFAULT_LIMIT; i++) begin
      add_row(1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, occ_vec_t'(i + 1), '0);
    end
    add_row(1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h00000010, 'h000000000001);
    add_row(0, 0, 1, 0, 5, 0, 0, 0, 0, 0, 0, 0, 'h0000000b, 'h000000000001);
    add_row(0, 0, 1, 1, 3, 0, 0, 0, 0, 0, 0, 1, 'h0000000b, 'h000000000001);
    add_row(1, 0, 1, 0, 4, 0, 0, 0, 0, 0, 1, 0, 'h00000008, 'h000000000001);
    add_row(1, 1, 1, 1, 6, 0, 0, 0, 0, 0, 1, 1, 'h00000108, 'h000000000001);
    add_row(1, 0, 0, 0, 0, 0, 1, CFG_LIMIT, 0, 8, 1, 0, 'h00000109, 'h000000000001);
    // judged on 9 against 8, not on 7 after the dequeue
    add_row(1, 0, 1, 0, 2, 0, 0, 0, 0, 0, 0, 0, 'h00000107, 'h000000000002);
    add_row(1, 0, 0, 0, 0, 0, 1, CFG_OCC, 0, 'h30, 1, 0, 'h00000130, 'h000000000002);
    add_row(1, 0, 0, 0, 0, 0, 1, CFG_DROP, 0, 5, 0, 0, 'h00000130, 'h000000000005);
    add_row(1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 'h00010130, 'h000000000005);
    add_row(1, 1, 0, 0, 0, 'h1, 0, 0, 0, 0, 1, 0, 'h00010200, 'h000000000000);
    add_row(1, 2, 0, 0, 0, 'h4, 1, CFG_DROP, 3, 9, 1, 0, 'h00000200, 'h009000000000);
    add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h00000200, 'h009000000000);

    wait_cycles = 0;
    while ((rst_n !== 1'b1) && (wait_cycles < 20)) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", wait_cycles);
      other_count++;
    end else begin
      @(posedge clk);
      #1;
      // state straight out of reset
      compare_value("occupancy", occupancy, '0);
      compare_value("drops", drops, '0);
      compare_value("peak", peak, '0);
      compare_value("enq_accept", enq_accept, 1'b0);
      compare_value("deq_underflow", deq_underflow, 1'b0);
      foreach (rows[i]) begin
        apply_row(rows[i], 1'b1);
      end
      repeat (200) begin
        apply_row(random_row(), 1'b0);
      end
      drive_inputs('0);
    end

    $display("errors: %0d mismatches, %0d assertion failures, %0d other failures",
             mismatch_count, uut.u_chk.fail_count, other_count);
    if ((mismatch_count == 0) && (uut.u_chk.fail_count == 0) && (other_count == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/cq_cfg_pkg.sv
verilog/cq_types_pkg.sv
verilog/counter_bank.sv
verilog/credit_admit.sv
verilog/occupancy_peak.sv
verilog/credit_monitor_top.sv
verif/credit_monitor_chk.sv
verif/credit_monitor_tb.sv
